//--- systolic_pkg.sv
package systolic_pkg;

    // grid geometry
    localparam int GRID_SIZE = 4;

    // operand and product widths
    localparam int DATA_WIDTH = 8;
    localparam int NUM_DIGITS = 3;
    localparam int PROD_WIDTH = 16;

    // 16 worst-case products of 2^14 fit with headroom
    localparam int ACC_WIDTH = 20;

    // select, compress, accumulate
    localparam int PE_LATENCY = 3;

    typedef logic signed [DATA_WIDTH-1:0] operand_t;

    // 3 * -128 = -384 needs two extra bits
    typedef logic signed [DATA_WIDTH+1:0] triple_t;

    // sign-magnitude radix-8 digit, magnitude 0..4
    typedef struct packed {
        logic       neg;
        logic [2:0] mag;
    } booth_digit_t;

    // digit k carries weight 8^k
    typedef booth_digit_t [NUM_DIGITS-1:0] digit_vec_t;

    typedef logic signed [ACC_WIDTH-1:0] acc_t;

endpackage

//--- operand_if.sv
`timescale 1ns/1ps

interface operand_if;
    import systolic_pkg::*;

    // one cycle per accepted vector
    logic valid;

    // run boundaries
    logic first;
    logic last;

    // recoded A column, one digit set per grid row
    digit_vec_t [GRID_SIZE-1:0] digits;

    // B row and its triple, one per grid column
    operand_t [GRID_SIZE-1:0] mult;
    triple_t  [GRID_SIZE-1:0] mult3;

    modport prod (
        output valid,
        output first,
        output last,
        output digits,
        output mult,
        output mult3
    );

    modport cons (
        input valid,
        input first,
        input last,
        input digits,
        input mult,
        input mult3
    );

endinterface

//--- operand_prep.sv
`timescale 1ns/1ps

module operand_prep (
    input  logic                                             clk,
    input  logic                                             rst,
    input  logic                                             in_req,
    input  logic                                             in_first,
    input  logic                                             in_last,
    input  systolic_pkg::operand_t [systolic_pkg::GRID_SIZE-1:0] a_col,
    input  systolic_pkg::operand_t [systolic_pkg::GRID_SIZE-1:0] b_row,
    output logic                                             in_ack,
    operand_if.prod                                          op
);
    import systolic_pkg::*;

    typedef enum logic {
        S_IDLE,
        S_ACK
    } hs_state_t;

    hs_state_t state;
    logic      accept;
    logic      accepted;
    logic      run_first;
    logic      run_last;

    operand_t   [GRID_SIZE-1:0] a_reg;
    operand_t   [GRID_SIZE-1:0] b_reg;
    digit_vec_t [GRID_SIZE-1:0] digits_nxt;
    triple_t    [GRID_SIZE-1:0] mult3_nxt;

    // value of one 4-bit overlapping group: -4*g3 + 2*g2 + g1 + g0
    function automatic booth_digit_t recode_group(input logic [3:0] grp);
        logic signed [3:0] val;
        booth_digit_t      dig;
        val = $signed({grp[3], grp[3], 2'b00}) + $signed({2'b00, grp[2], 1'b0})
            + $signed({3'b000, grp[1]}) + $signed({3'b000, grp[0]});
        dig.neg = val[3];
        dig.mag = val[3] ? 3'(-val) : 3'(val);
        return dig;
    endfunction

    // four-phase handshake, ack follows req with one edge of delay
    assign accept = (state == S_IDLE) && in_req;
    assign in_ack = (state == S_ACK);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: if (in_req) state <= S_ACK;
                S_ACK:  if (!in_req) state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    // capture on acceptance
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            accepted  <= 1'b0;
            run_first <= 1'b0;
            run_last  <= 1'b0;
        end else begin
            accepted <= accept;
            if (accept) begin
                run_first <= in_first;
                run_last  <= in_last;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            a_reg <= a_col;
            b_reg <= b_row;
        end
    end

    // booth recoding and 3B, one adder per column
    always_comb begin
        logic [3*NUM_DIGITS:0] ext;
        for (int idx = 0; idx < GRID_SIZE; idx++) begin
            ext = {{(3*NUM_DIGITS-DATA_WIDTH){a_reg[idx][DATA_WIDTH-1]}}, a_reg[idx], 1'b0};
            for (int k = 0; k < NUM_DIGITS; k++) begin
                digits_nxt[idx][k] = recode_group(ext[3*k +: 4]);
            end
            mult3_nxt[idx] = (triple_t'(b_reg[idx]) <<< 1) + triple_t'(b_reg[idx]);
        end
    end

    // registered issue into the grid
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            op.valid <= 1'b0;
            op.first <= 1'b0;
            op.last  <= 1'b0;
        end else begin
            op.valid <= accepted;
            op.first <= run_first;
            op.last  <= run_last;
        end
    end

    always_ff @(posedge clk) begin
        op.digits <= digits_nxt;
        op.mult   <= b_reg;
        op.mult3  <= mult3_nxt;
    end

endmodule

//--- booth_pe.sv
`timescale 1ns/1ps

module booth_pe (
    input  logic                     clk,
    input  logic                     rst,
    input  systolic_pkg::digit_vec_t digits_in,
    input  logic                     valid_in,
    input  logic                     first_in,
    input  logic                     last_in,
    input  systolic_pkg::operand_t   mult_in,
    input  systolic_pkg::triple_t    mult3_in,
    output systolic_pkg::digit_vec_t digits_out,
    output logic                     valid_out,
    output logic                     first_out,
    output logic                     last_out,
    output systolic_pkg::operand_t   mult_out,
    output systolic_pkg::triple_t    mult3_out,
    output systolic_pkg::acc_t       acc,
    output logic                     acc_last,
    output logic                     acc_first
);
    import systolic_pkg::*;

    logic signed [PROD_WIDTH-1:0] pp_nxt [NUM_DIGITS];
    logic signed [PROD_WIDTH-1:0] pp_q   [NUM_DIGITS];
    logic signed [PROD_WIDTH-1:0] cs_sum_nxt;
    logic signed [PROD_WIDTH-1:0] cs_carry_nxt;
    logic signed [PROD_WIDTH-1:0] cs_sum_q;
    logic signed [PROD_WIDTH-1:0] cs_carry_q;
    logic signed [PROD_WIDTH-1:0] product;

    // flags riding alongside stages 1 and 2
    logic [PE_LATENCY-2:0] valid_pipe;
    logic [PE_LATENCY-2:0] first_pipe;
    logic [PE_LATENCY-2:0] last_pipe;

    // systolic forwarding, digits east and multiplicands south
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid_out <= 1'b0;
            first_out <= 1'b0;
            last_out  <= 1'b0;
        end else begin
            valid_out <= valid_in;
            first_out <= first_in;
            last_out  <= last_in;
        end
    end

    always_ff @(posedge clk) begin
        digits_out <= digits_in;
        mult_out   <= mult_in;
        mult3_out  <= mult3_in;
    end

    // stage 1: pick 0, B, 2B, 3B or 4B per digit, apply sign, weight by 8^k
    always_comb begin
        logic signed [DATA_WIDTH+2:0] multiple;
        for (int k = 0; k < NUM_DIGITS; k++) begin
            case (digits_in[k].mag)
                3'd1:    multiple = (DATA_WIDTH+3)'(mult_in);
                3'd2:    multiple = (DATA_WIDTH+3)'(mult_in) <<< 1;
                3'd3:    multiple = (DATA_WIDTH+3)'(mult3_in);
                3'd4:    multiple = (DATA_WIDTH+3)'(mult_in) <<< 2;
                default: multiple = '0;
            endcase
            if (digits_in[k].neg) begin
                multiple = -multiple;
            end
            pp_nxt[k] = PROD_WIDTH'(multiple) <<< (3*k);
        end
    end

    always_ff @(posedge clk) begin
        pp_q <= pp_nxt;
    end

    // stage 2: 3:2 carry-save layer, bit by bit
    always_comb begin
        cs_carry_nxt[0] = 1'b0;
        for (int b = 0; b < PROD_WIDTH; b++) begin
            cs_sum_nxt[b] = pp_q[0][b] ^ pp_q[1][b] ^ pp_q[2][b];
        end
        // carry out of the top bit falls off, the product fits in 16 bits
        for (int b = 0; b < PROD_WIDTH - 1; b++) begin
            cs_carry_nxt[b+1] = (pp_q[0][b] & pp_q[1][b]) | (pp_q[0][b] & pp_q[2][b])
                              | (pp_q[1][b] & pp_q[2][b]);
        end
    end

    always_ff @(posedge clk) begin
        cs_sum_q   <= cs_sum_nxt;
        cs_carry_q <= cs_carry_nxt;
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid_pipe <= '0;
            first_pipe <= '0;
            last_pipe  <= '0;
        end else begin
            valid_pipe <= {valid_pipe[PE_LATENCY-3:0], valid_in};
            first_pipe <= {first_pipe[PE_LATENCY-3:0], first_in};
            last_pipe  <= {last_pipe[PE_LATENCY-3:0], last_in};
        end
    end

    // stage 3: carry-propagate add, then load or accumulate
    assign product = cs_sum_q + cs_carry_q;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            acc       <= '0;
            acc_last  <= 1'b0;
            acc_first <= 1'b0;
        end else begin
            acc_last  <= valid_pipe[PE_LATENCY-2] & last_pipe[PE_LATENCY-2];
            acc_first <= valid_pipe[PE_LATENCY-2] & first_pipe[PE_LATENCY-2];
            if (valid_pipe[PE_LATENCY-2]) begin
                if (first_pipe[PE_LATENCY-2]) begin
                    acc <= ACC_WIDTH'(product);
                end else begin
                    acc <= acc + ACC_WIDTH'(product);
                end
            end
        end
    end

endmodule

//--- pe_grid.sv
`timescale 1ns/1ps

module pe_grid (
    input  logic                                                       clk,
    input  logic                                                       rst,
    operand_if.cons                                                    op,
    output systolic_pkg::acc_t [systolic_pkg::GRID_SIZE*systolic_pkg::GRID_SIZE-1:0] acc,
    output logic [systolic_pkg::GRID_SIZE*systolic_pkg::GRID_SIZE-1:0] acc_last,
    output logic                                                       acc_first_corner
);
    import systolic_pkg::*;

    // row links indexed by the PE they feed, last column spills off the edge
    digit_vec_t row_digits [GRID_SIZE][GRID_SIZE+1];
    logic       row_valid  [GRID_SIZE][GRID_SIZE+1];
    logic       row_first  [GRID_SIZE][GRID_SIZE+1];
    logic       row_last   [GRID_SIZE][GRID_SIZE+1];

    // column links, same idea going south
    operand_t   col_mult   [GRID_SIZE+1][GRID_SIZE];
    triple_t    col_mult3  [GRID_SIZE+1][GRID_SIZE];

    logic [GRID_SIZE*GRID_SIZE-1:0] pe_first;

    assign acc_first_corner = pe_first[0];

    // row i enters i cycles late
    for (genvar i = 0; i < GRID_SIZE; i++) begin : g_row_skew
        if (i == 0) begin : g_direct
            assign row_digits[i][0] = op.digits[i];
            assign row_valid[i][0]  = op.valid;
            assign row_first[i][0]  = op.first;
            assign row_last[i][0]   = op.last;
        end else begin : g_delay
            digit_vec_t   dig_sr [i];
            logic [i-1:0] val_sr;
            logic [i-1:0] first_sr;
            logic [i-1:0] last_sr;

            always_ff @(posedge clk or negedge rst) begin
                if (!rst) begin
                    val_sr   <= '0;
                    first_sr <= '0;
                    last_sr  <= '0;
                end else begin
                    val_sr[0]   <= op.valid;
                    first_sr[0] <= op.first;
                    last_sr[0]  <= op.last;
                    for (int s = 1; s < i; s++) begin
                        val_sr[s]   <= val_sr[s-1];
                        first_sr[s] <= first_sr[s-1];
                        last_sr[s]  <= last_sr[s-1];
                    end
                end
            end

            always_ff @(posedge clk) begin
                dig_sr[0] <= op.digits[i];
                for (int s = 1; s < i; s++) begin
                    dig_sr[s] <= dig_sr[s-1];
                end
            end

            assign row_digits[i][0] = dig_sr[i-1];
            assign row_valid[i][0]  = val_sr[i-1];
            assign row_first[i][0]  = first_sr[i-1];
            assign row_last[i][0]   = last_sr[i-1];
        end
    end

    // column j enters j cycles late
    for (genvar j = 0; j < GRID_SIZE; j++) begin : g_col_skew
        if (j == 0) begin : g_direct
            assign col_mult[0][j]  = op.mult[j];
            assign col_mult3[0][j] = op.mult3[j];
        end else begin : g_delay
            operand_t mult_sr  [j];
            triple_t  mult3_sr [j];

            always_ff @(posedge clk) begin
                mult_sr[0]  <= op.mult[j];
                mult3_sr[0] <= op.mult3[j];
                for (int s = 1; s < j; s++) begin
                    mult_sr[s]  <= mult_sr[s-1];
                    mult3_sr[s] <= mult3_sr[s-1];
                end
            end

            assign col_mult[0][j]  = mult_sr[j-1];
            assign col_mult3[0][j] = mult3_sr[j-1];
        end
    end

    for (genvar i = 0; i < GRID_SIZE; i++) begin : g_pe_row
        for (genvar j = 0; j < GRID_SIZE; j++) begin : g_pe_col
            booth_pe i_pe (
                .clk        (clk),
                .rst        (rst),
                .digits_in  (row_digits[i][j]),
                .valid_in   (row_valid[i][j]),
                .first_in   (row_first[i][j]),
                .last_in    (row_last[i][j]),
                .mult_in    (col_mult[i][j]),
                .mult3_in   (col_mult3[i][j]),
                .digits_out (row_digits[i][j+1]),
                .valid_out  (row_valid[i][j+1]),
                .first_out  (row_first[i][j+1]),
                .last_out   (row_last[i][j+1]),
                .mult_out   (col_mult[i+1][j]),
                .mult3_out  (col_mult3[i+1][j]),
                .acc        (acc[i*GRID_SIZE+j]),
                .acc_last   (acc_last[i*GRID_SIZE+j]),
                .acc_first  (pe_first[i*GRID_SIZE+j])
            );
        end
    end

endmodule

//--- result_collector.sv
`timescale 1ns/1ps

module result_collector (
    input  logic                                                       clk,
    input  logic                                                       rst,
    input  systolic_pkg::acc_t [systolic_pkg::GRID_SIZE*systolic_pkg::GRID_SIZE-1:0] acc,
    input  logic [systolic_pkg::GRID_SIZE*systolic_pkg::GRID_SIZE-1:0] acc_last,
    input  logic                                                       acc_first_corner,
    output systolic_pkg::acc_t [systolic_pkg::GRID_SIZE*systolic_pkg::GRID_SIZE-1:0] c_mat,
    output logic                                                       done
);
    import systolic_pkg::*;

    // each element latches its own final sum
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            c_mat <= '0;
        end else begin
            for (int k = 0; k < GRID_SIZE*GRID_SIZE; k++) begin
                if (acc_last[k]) begin
                    c_mat[k] <= acc[k];
                end
            end
        end
    end

    // corner PE finishes last, PE(0,0) starts first
    // a new run starting takes priority, the result shown is then stale
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            done <= 1'b0;
        end else if (acc_first_corner) begin
            done <= 1'b0;
        end else if (acc_last[GRID_SIZE*GRID_SIZE-1]) begin
            done <= 1'b1;
        end
    end

endmodule

//--- systolic_mac_top.sv
`timescale 1ns/1ps

module systolic_mac_top (
    input  logic                                                       clk,
    input  logic                                                       rst,
    input  logic                                                       in_req,
    input  logic                                                       in_first,
    input  logic                                                       in_last,
    input  systolic_pkg::operand_t [systolic_pkg::GRID_SIZE-1:0]       a_col,
    input  systolic_pkg::operand_t [systolic_pkg::GRID_SIZE-1:0]       b_row,
    output logic                                                       in_ack,
    output systolic_pkg::acc_t [systolic_pkg::GRID_SIZE*systolic_pkg::GRID_SIZE-1:0] c_mat,
    output logic                                                       done
);
    import systolic_pkg::*;

    acc_t [GRID_SIZE*GRID_SIZE-1:0] pe_acc;
    logic [GRID_SIZE*GRID_SIZE-1:0] pe_acc_last;
    logic                           pe_acc_first;

    // producer to grid
    operand_if i_op_if ();

    operand_prep i_operand_prep (
        .clk      (clk),
        .rst      (rst),
        .in_req   (in_req),
        .in_first (in_first),
        .in_last  (in_last),
        .a_col    (a_col),
        .b_row    (b_row),
        .in_ack   (in_ack),
        .op       (i_op_if.prod)
    );

    pe_grid i_pe_grid (
        .clk              (clk),
        .rst              (rst),
        .op               (i_op_if.cons),
        .acc              (pe_acc),
        .acc_last         (pe_acc_last),
        .acc_first_corner (pe_acc_first)
    );

    result_collector i_result_collector (
        .clk              (clk),
        .rst              (rst),
        .acc              (pe_acc),
        .acc_last         (pe_acc_last),
        .acc_first_corner (pe_acc_first),
        .c_mat            (c_mat),
        .done             (done)
    );

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    localparam int HALF_PERIOD  = 50;
    localparam int RESET_CYCLES = 5;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // active low, released on a rising edge
    initial begin
        rst = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b1;
    end

endmodule

//--- systolic_mac_tb.sv
`timescale 1ns/1ps

module systolic_mac_tb;
    import systolic_pkg::*;

    localparam int MAX_K     = 16;
    localparam int TIMEOUT   = 200;
    localparam int NUM_TESTS = 11;
    localparam int NUM_ELEMS = GRID_SIZE * GRID_SIZE;

    // operand fill modes
    localparam int FILL_PATTERN = 0;
    localparam int FILL_IDENT   = 1;
    localparam int FILL_NEG     = 2;
    localparam int FILL_MIN     = 3;
    localparam int FILL_MAX     = 4;
    localparam int FILL_RAND    = 5;

    // check kinds
    localparam int CHK_RESET   = 0;
    localparam int CHK_PRODUCT = 1;
    localparam int CHK_RESTART = 2;

    logic                           clk;
    logic                           rst;
    logic                           in_req;
    logic                           in_first;
    logic                           in_last;
    operand_t [GRID_SIZE-1:0]       a_col;
    operand_t [GRID_SIZE-1:0]       b_row;
    logic                           in_ack;
    acc_t     [NUM_ELEMS-1:0]       c_mat;
    logic                           done;

    // stimulus table
    string tbl_name   [NUM_TESTS];
    int    tbl_k      [NUM_TESTS];
    int    tbl_a_fill [NUM_TESTS];
    int    tbl_b_fill [NUM_TESTS];
    int    tbl_check  [NUM_TESTS];

    int a_mat  [GRID_SIZE][MAX_K];
    int b_mat  [MAX_K][GRID_SIZE];
    int exp_c  [GRID_SIZE][GRID_SIZE];
    int prev_c [GRID_SIZE][GRID_SIZE];

    tb_clock_gen i_clock_gen (
        .clk (clk),
        .rst (rst)
    );

    systolic_mac_top i_systolic_mac_top (
        .clk      (clk),
        .rst      (rst),
        .in_req   (in_req),
        .in_first (in_first),
        .in_last  (in_last),
        .a_col    (a_col),
        .b_row    (b_row),
        .in_ack   (in_ack),
        .c_mat    (c_mat),
        .done     (done)
    );

    task automatic add_entry(input int idx, input string name, input int k,
                             input int a_fill, input int b_fill, input int check);
        tbl_name[idx]   = name;
        tbl_k[idx]      = k;
        tbl_a_fill[idx] = a_fill;
        tbl_b_fill[idx] = b_fill;
        tbl_check[idx]  = check;
    endtask

    task automatic build_table();
        add_entry(0, "reset_state", 0, FILL_PATTERN, FILL_PATTERN, CHK_RESET);
        add_entry(1, "outer_product", 1, FILL_PATTERN, FILL_PATTERN, CHK_PRODUCT);
        add_entry(2, "identity_a", 4, FILL_IDENT, FILL_PATTERN, CHK_PRODUCT);
        add_entry(3, "all_negative", 4, FILL_NEG, FILL_NEG, CHK_PRODUCT);
        add_entry(4, "negative_identity_b", 4, FILL_NEG, FILL_IDENT, CHK_PRODUCT);
        add_entry(5, "min_times_min", MAX_K, FILL_MIN, FILL_MIN, CHK_PRODUCT);
        add_entry(6, "min_times_max", MAX_K, FILL_MIN, FILL_MAX, CHK_PRODUCT);
        add_entry(7, "max_times_max", MAX_K, FILL_MAX, FILL_MAX, CHK_PRODUCT);
        add_entry(8, "random_k4", 4, FILL_RAND, FILL_RAND, CHK_PRODUCT);
        add_entry(9, "random_max_k", MAX_K, FILL_RAND, FILL_RAND, CHK_RESTART);
        add_entry(10, "restart_k1", 1, FILL_PATTERN, FILL_RAND, CHK_RESTART);
    endtask

    // salt keeps the A and B patterns apart
    function automatic int fill_value(input int mode, input int r, input int c, input int salt);
        case (mode)
            FILL_PATTERN: return ((r * 7 + c * 3 + salt) % 11) - 5;
            FILL_IDENT:   return (r == c) ? 1 : 0;
            FILL_NEG:     return -1 - ((r * 3 + c * 5 + salt) % 9);
            FILL_MIN:     return -128;
            FILL_MAX:     return 127;
            default:      return int'($urandom & 32'hff) - 128;
        endcase
    endfunction

    // reference C as plain integer sums over A (GRID_SIZE x K) and B (K x GRID_SIZE)
    task automatic build_operands(input int t);
        for (int k = 0; k < tbl_k[t]; k++) begin
            for (int i = 0; i < GRID_SIZE; i++) begin
                a_mat[i][k] = fill_value(tbl_a_fill[t], i, k, 1);
                b_mat[k][i] = fill_value(tbl_b_fill[t], k, i, 4);
            end
        end
        for (int i = 0; i < GRID_SIZE; i++) begin
            for (int j = 0; j < GRID_SIZE; j++) begin
                exp_c[i][j] = 0;
                for (int k = 0; k < tbl_k[t]; k++) begin
                    exp_c[i][j] += a_mat[i][k] * b_mat[k][j];
                end
            end
        end
    endtask

    // one four-phase transfer entered and left on a falling edge
    task automatic send_vector(input int t, input int k, output bit hs_err, output bit timed_out);
        int cycles;
        hs_err = 1'b0;
        timed_out = 1'b0;
        @(posedge clk);
        for (int i = 0; i < GRID_SIZE; i++) begin
            a_col[i] <= operand_t'(a_mat[i][k]);
            b_row[i] <= operand_t'(b_mat[k][i]);
        end
        in_first <= (k == 0);
        in_last  <= (k == tbl_k[t] - 1);
        in_req   <= 1'b1;
        cycles = 0;
        @(negedge clk);
        // req raised but not yet sampled by the DUT
        if (in_ack !== 1'b0) begin
            $display("test %s: in_ack was high before vector %0d was taken", tbl_name[t], k);
            hs_err = 1'b1;
        end
        while (in_ack !== 1'b1 && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (in_ack !== 1'b1) begin
            $display("test %s: in_ack never rose for vector %0d", tbl_name[t], k);
            timed_out = 1'b1;
        end else begin
            @(posedge clk);
            in_req   <= 1'b0;
            in_first <= 1'b0;
            in_last  <= 1'b0;
            @(negedge clk);
            // req drop not yet seen by the DUT
            if (in_ack !== 1'b1) begin
                $display("test %s: in_ack fell before in_req was released", tbl_name[t]);
                hs_err = 1'b1;
            end
            cycles = 0;
            while (in_ack !== 1'b0 && cycles < TIMEOUT) begin
                @(negedge clk);
                cycles++;
            end
            if (in_ack !== 1'b0) begin
                $display("test %s: in_ack never fell after vector %0d", tbl_name[t], k);
                timed_out = 1'b1;
            end
        end
    endtask

    // done of a previous run must fall first and then rise for this one
    task automatic wait_done(input int t, output bit timed_out);
        int cycles;
        timed_out = 1'b0;
        cycles = 0;
        while (done !== 1'b0 && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (done !== 1'b0) begin
            $display("test %s: done did not fall after the new run started", tbl_name[t]);
            timed_out = 1'b1;
        end else begin
            cycles = 0;
            while (done !== 1'b1 && cycles < TIMEOUT) begin
                @(negedge clk);
                cycles++;
            end
            if (done !== 1'b1) begin
                $display("test %s: done did not rise after the last vector", tbl_name[t]);
                timed_out = 1'b1;
            end
        end
    endtask

    task automatic check_matrix(input int t, input bit against_prev, inout int mismatches);
        int expected;
        int actual;
        for (int i = 0; i < GRID_SIZE; i++) begin
            for (int j = 0; j < GRID_SIZE; j++) begin
                expected = against_prev ? prev_c[i][j] : exp_c[i][j];
                actual   = $signed(c_mat[i*GRID_SIZE+j]);
                if (actual != expected) begin
                    $display("ERR %s c[%0d][%0d] expected %0d actual %0d",
                             tbl_name[t], i, j, expected, actual);
                    mismatches++;
                end
            end
        end
    endtask

    task automatic run_test(input int t, output int mismatches, output bit timed_out);
        bit hs_err;
        bit step_to;
        mismatches = 0;
        timed_out = 1'b0;
        if (tbl_check[t] == CHK_RESET) begin
            for (int i = 0; i < GRID_SIZE; i++) begin
                for (int j = 0; j < GRID_SIZE; j++) begin
                    exp_c[i][j] = 0;
                end
            end
            if (in_ack !== 1'b0) begin
                $display("ERR %s in_ack expected 0 actual %b", tbl_name[t], in_ack);
                mismatches++;
            end
            if (done !== 1'b0) begin
                $display("ERR %s done expected 0 actual %b", tbl_name[t], done);
                mismatches++;
            end
            check_matrix(t, 1'b0, mismatches);
        end else begin
            build_operands(t);
            for (int k = 0; k < tbl_k[t] && !timed_out; k++) begin
                send_vector(t, k, hs_err, step_to);
                if (hs_err) begin
                    mismatches++;
                end
                timed_out = step_to;
                // first vector taken while the old result is still on show
                if (k == 0 && !timed_out && tbl_check[t] == CHK_RESTART) begin
                    if (done !== 1'b1) begin
                        $display("ERR %s done expected 1 actual %b", tbl_name[t], done);
                        mismatches++;
                    end
                    check_matrix(t, 1'b1, mismatches);
                end
            end
            if (!timed_out) begin
                wait_done(t, step_to);
                timed_out = step_to;
            end
            if (!timed_out) begin
                check_matrix(t, 1'b0, mismatches);
            end
        end
        prev_c = exp_c;
    endtask

    initial begin
        int  pass_count;
        int  fail_count;
        int  mismatches;
        int  cycles;
        bit  timed_out;
        bit  aborted;
        in_req     = 1'b0;
        in_first   = 1'b0;
        in_last    = 1'b0;
        a_col      = '0;
        b_row      = '0;
        pass_count = 0;
        fail_count = 0;
        aborted    = 1'b0;
        void'($urandom(32'hd49c849c));
        build_table();

        cycles = 0;
        while (rst !== 1'b1 && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (rst !== 1'b1) begin
            $display("reset was never released");
            fail_count++;
            aborted = 1'b1;
        end
        @(negedge clk);

        for (int t = 0; t < NUM_TESTS && !aborted; t++) begin
            run_test(t, mismatches, timed_out);
            if (mismatches == 0 && !timed_out) begin
                $display("test %s: pass", tbl_name[t]);
                pass_count++;
            end else begin
                $display("test %s: fail, %0d mismatches", tbl_name[t], mismatches);
                fail_count++;
            end
            // a stuck handshake leaves the DUT in an unknown state
            if (timed_out) begin
                aborted = 1'b1;
            end
        end

        $display("tests run: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- compile.f
systolic_pkg.sv
operand_if.sv
operand_prep.sv
booth_pe.sv
pe_grid.sv
result_collector.sv
systolic_mac_top.sv
tb_clock_gen.sv
systolic_mac_tb.sv
